// File: rtl/isa_pkg.sv
// architectural register definitions

package isa_pkg;

    // ==============================
    // integer register file
    // ==============================

    // count of architectural integer registers
    localparam int NUM_ARCH_REGS = 32;

    // index into the architectural file
    typedef logic [$clog2(NUM_ARCH_REGS)-1:0] arch_reg_t;

    // x0 reads as zero and is never renamed
    localparam arch_reg_t ZERO_REG = arch_reg_t'(0);

endpackage

// File: rtl/uarch_pkg.sv
// physical register limits

package uarch_pkg;

    // ==============================
    // physical register file
    // ==============================

    // bits in a physical register tag
    localparam int PREG_IDX_W = 7;

    // physical register tag
    typedef logic [PREG_IDX_W-1:0] preg_t;

    // biggest file a tag can address
    localparam int MAX_PHYS_REGS = 1 << PREG_IDX_W;

endpackage

// File: rtl/free_list.sv
// physical register free list

module free_list
    import uarch_pkg::*;
    import isa_pkg::*;
#(
    parameter int PHYS_REGS = 64
) (
    input  logic                clock,
    input  logic                reset,

    // dispatch side
    input  logic                alloc_req_i,
    output logic                alloc_valid_o,
    output preg_t               alloc_preg_o,

    // commit side
    input  logic                release_valid_i,
    input  preg_t               release_preg_i,

    // recovery
    input  logic                flush_i,

    // status
    output logic                empty_o,
    output logic [PREG_IDX_W:0] free_count_o
);

    // ==============================
    // sizing
    // ==============================

    // one slot per register outside the committed map
    localparam int CAPACITY = PHYS_REGS - NUM_ARCH_REGS;
    // at least one bit for a single slot
    localparam int PTR_W = (CAPACITY > 1) ? $clog2(CAPACITY) : 1;
    localparam logic [PREG_IDX_W:0] CAP_CNT = (PREG_IDX_W + 1)'(CAPACITY);
    localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(CAPACITY - 1);

    // ==============================
    // state
    // ==============================

    preg_t                queue [CAPACITY];
    // next slot to hand out
    logic [PTR_W-1:0]     head;
    // next slot to fill on release
    logic [PTR_W-1:0]     tail;
    // oldest slot still held by an uncommitted instruction
    logic [PTR_W-1:0]     commit_head;
    logic [PREG_IDX_W:0]  count;

    // slots from commit head up to tail
    logic [PTR_W:0]       span;
    logic [PREG_IDX_W:0]  flush_count;

    // circular increment
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == LAST_SLOT) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // ==============================
    // allocate
    // ==============================

    assign empty_o = (count == '0);
    assign free_count_o = count;

    // pop from the head without bypass from this cycle's release
    assign alloc_valid_o = alloc_req_i && !empty_o;
    assign alloc_preg_o = queue[head];

    // ==============================
    // flush recovery
    // ==============================

    // squashed registers still sit between commit head and head
    always_comb begin
        if (tail >= commit_head) begin
            span = {1'b0, tail} - {1'b0, commit_head};
        end else begin
            span = {1'b0, tail} + (PTR_W + 1)'(CAPACITY) - {1'b0, commit_head};
        end
    end

    // equal pointers mean a full ring here
    // an empty span would need every register committed
    assign flush_count = (span == '0) ? CAP_CNT : (PREG_IDX_W + 1)'(span);

    // ==============================
    // update
    // ==============================

    always_ff @(posedge clock) begin
        if (reset) begin
            // full ring holding the non-identity registers
            head        <= '0;
            tail        <= '0;
            commit_head <= '0;
            count       <= CAP_CNT;
            for (int i = 0; i < CAPACITY; i++) begin
                queue[i] <= preg_t'(NUM_ARCH_REGS + i);
            end
        end else begin
            // displaced register goes to the back
            if (release_valid_i) begin
                queue[tail] <= release_preg_i;
                tail        <= ptr_inc(tail);
                // one release per committed allocation
                commit_head <= ptr_inc(commit_head);
            end

            if (flush_i) begin
                // rewind to the oldest uncommitted allocation
                head  <= commit_head;
                count <= flush_count;
            end else begin
                if (alloc_valid_o) begin
                    head <= ptr_inc(head);
                end
                count <= count + {{PREG_IDX_W{1'b0}}, release_valid_i}
                               - {{PREG_IDX_W{1'b0}}, alloc_valid_o};
            end
        end
    end

    // ==============================
    // checks
    // ==============================

    a_count_bound: assert property (@(posedge clock) disable iff (reset)
        count <= CAP_CNT)
        else $error("free list count above capacity");

    // commit must not return more than was handed out
    a_release_not_full: assert property (@(posedge clock) disable iff (reset)
        release_valid_i |-> count != CAP_CNT)
        else $error("release into a full free list");

    // the ring between head and tail must really hold a free slot
    a_no_alloc_empty: assert property (@(posedge clock) disable iff (reset)
        alloc_valid_o |-> (head != tail) || (count == CAP_CNT))
        else $error("allocation from an empty free list");

endmodule

// File: rtl/map_table.sv
// speculative rename map

module map_table
    import isa_pkg::*;
    import uarch_pkg::*;
#(
    parameter int PHYS_REGS = 64
) (
    input  logic      clock,
    input  logic      reset,

    // lookups for the dispatching instruction
    input  arch_reg_t src1_i,
    input  arch_reg_t src2_i,
    input  arch_reg_t dest_i,
    output preg_t     src1_preg_o,
    output preg_t     src2_preg_o,
    output preg_t     old_preg_o,

    // new destination mapping
    input  logic      write_i,
    input  preg_t     write_preg_i,

    // recovery from the committed map
    input  logic      flush_i,
    input  preg_t     restore_map_i [NUM_ARCH_REGS]
);

    // ==============================
    // map storage
    // ==============================

    preg_t map [NUM_ARCH_REGS];

    // ==============================
    // read ports
    // ==============================

    // state before this cycle's write
    // same-cycle dependencies are resolved upstream
    assign src1_preg_o = map[src1_i];
    assign src2_preg_o = map[src2_i];
    // mapping about to be displaced
    assign old_preg_o = map[dest_i];

    // ==============================
    // update
    // ==============================

    always_ff @(posedge clock) begin
        if (reset) begin
            // identity map
            for (int i = 0; i < NUM_ARCH_REGS; i++) begin
                map[i] <= preg_t'(i);
            end
        end else if (flush_i) begin
            // squash wins over any rename this cycle
            map <= restore_map_i;
        end else if (write_i) begin
            map[dest_i] <= write_preg_i;
        end
    end

    // ==============================
    // checks
    // ==============================

    // x0 stays pinned to physical 0
    a_no_zero_write: assert property (@(posedge clock) disable iff (reset)
        write_i |-> dest_i != ZERO_REG)
        else $error("rename of x0");

    for (genvar g = 0; g < NUM_ARCH_REGS; g++) begin : g_entry_check
        a_entry_bound: assert property (@(posedge clock) disable iff (reset)
            int'(map[g]) < PHYS_REGS)
            else $error("map entry %0d outside the physical file", g);
    end

endmodule

// File: rtl/arch_map.sv
// committed rename map

module arch_map
    import isa_pkg::*;
    import uarch_pkg::*;
#(
    parameter int PHYS_REGS = 64
) (
    input  logic      clock,
    input  logic      reset,

    // retiring instruction
    input  logic      commit_valid_i,
    input  arch_reg_t commit_arch_i,
    input  preg_t     commit_preg_i,

    // recovery strobe
    input  logic      flush_i,

    // register freed by this commit
    output logic      release_valid_o,
    output preg_t     release_preg_o,

    // whole table for flush restore
    output preg_t     map_o [NUM_ARCH_REGS]
);

    // ==============================
    // committed state
    // ==============================

    preg_t committed [NUM_ARCH_REGS];

    assign map_o = committed;

    // x0 commits carry no register
    assign release_valid_o = commit_valid_i && (commit_arch_i != ZERO_REG);
    // previous committed owner of the destination
    assign release_preg_o = committed[commit_arch_i];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < NUM_ARCH_REGS; i++) begin
                committed[i] <= preg_t'(i);
            end
        end else if (release_valid_o) begin
            committed[commit_arch_i] <= commit_preg_i;
        end
    end

    // ==============================
    // checks
    // ==============================

    // flush restores from a table that must be settled
    a_no_commit_flush: assert property (@(posedge clock) disable iff (reset)
        !(commit_valid_i && flush_i))
        else $error("commit and flush in the same cycle");

    a_commit_bound: assert property (@(posedge clock) disable iff (reset)
        release_valid_o |-> int'(commit_preg_i) < PHYS_REGS)
        else $error("committed register outside the physical file");

    // physical 0 belongs to x0 for good
    a_no_zero_release: assert property (@(posedge clock) disable iff (reset)
        release_valid_o |-> release_preg_o != '0)
        else $error("release of physical register 0");

endmodule

// File: rtl/rename_stage.sv
// register rename stage

module rename_stage
    import isa_pkg::*;
    import uarch_pkg::*;
#(
    parameter int PHYS_REGS = 64
) (
    input  logic                clock,
    input  logic                reset,

    // dispatch
    input  logic                dispatch_valid_i,
    input  logic                dispatch_has_dest_i,
    input  arch_reg_t           dispatch_dest_i,
    input  arch_reg_t           dispatch_src1_i,
    input  arch_reg_t           dispatch_src2_i,

    // commit
    input  logic                commit_valid_i,
    input  arch_reg_t           commit_arch_i,
    input  preg_t               commit_preg_i,

    // squash everything in flight
    input  logic                flush_i,

    // rename result, same cycle as dispatch
    output logic                rename_valid_o,
    output logic                stall_o,
    output preg_t               src1_preg_o,
    output preg_t               src2_preg_o,
    output preg_t               dest_preg_o,
    output preg_t               old_dest_preg_o,
    output logic [PREG_IDX_W:0] free_count_o
);

    // ==============================
    // elaboration check
    // ==============================

    // need at least one rename register, and tags wide enough
    if (PHYS_REGS <= NUM_ARCH_REGS || PHYS_REGS > MAX_PHYS_REGS) begin : g_bad_size
        $error("PHYS_REGS out of range");
    end

    // ==============================
    // internal wiring
    // ==============================

    logic  need_dest;
    logic  alloc_valid;
    preg_t alloc_preg;
    logic  release_valid;
    preg_t release_preg;
    logic  empty;
    preg_t old_preg;
    preg_t committed_map [NUM_ARCH_REGS];

    // x0 and no-dest instructions skip allocation
    assign need_dest = dispatch_valid_i && dispatch_has_dest_i &&
                       (dispatch_dest_i != ZERO_REG);

    // drop only when a needed register is missing
    assign rename_valid_o = dispatch_valid_i && !(need_dest && !alloc_valid);
    assign stall_o = empty;
    assign dest_preg_o = alloc_valid ? alloc_preg : '0;
    assign old_dest_preg_o = need_dest ? old_preg : '0;

    // ==============================
    // blocks
    // ==============================

    free_list #(.PHYS_REGS(PHYS_REGS)) free_list_i (
        .clock           (clock),
        .reset           (reset),
        .alloc_req_i     (need_dest),
        .alloc_valid_o   (alloc_valid),
        .alloc_preg_o    (alloc_preg),
        .release_valid_i (release_valid),
        .release_preg_i  (release_preg),
        .flush_i         (flush_i),
        .empty_o         (empty),
        .free_count_o    (free_count_o)
    );

    // written only on a successful allocation
    map_table #(.PHYS_REGS(PHYS_REGS)) map_table_i (
        .clock         (clock),
        .reset         (reset),
        .src1_i        (dispatch_src1_i),
        .src2_i        (dispatch_src2_i),
        .dest_i        (dispatch_dest_i),
        .src1_preg_o   (src1_preg_o),
        .src2_preg_o   (src2_preg_o),
        .old_preg_o    (old_preg),
        .write_i       (alloc_valid),
        .write_preg_i  (alloc_preg),
        .flush_i       (flush_i),
        .restore_map_i (committed_map)
    );

    // its release strobe also advances the free list commit head
    arch_map #(.PHYS_REGS(PHYS_REGS)) arch_map_i (
        .clock           (clock),
        .reset           (reset),
        .commit_valid_i  (commit_valid_i),
        .commit_arch_i   (commit_arch_i),
        .commit_preg_i   (commit_preg_i),
        .flush_i         (flush_i),
        .release_valid_o (release_valid),
        .release_preg_o  (release_preg),
        .map_o           (committed_map)
    );

endmodule

// File: sim/tb_rename_stage.sv
// rename stage testbench

module tb_rename_stage
    import isa_pkg::*;
    import uarch_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int PHYS_REGS = 64;
    localparam int CAPACITY = PHYS_REGS - NUM_ARCH_REGS;
    // about 90 cycles of tests plus a wide margin
    localparam int TIMEOUT_CYCLES = 2000;

    logic                clock;
    logic                reset;
    logic                dispatch_valid;
    logic                dispatch_has_dest;
    arch_reg_t           dispatch_dest;
    arch_reg_t           dispatch_src1;
    arch_reg_t           dispatch_src2;
    logic                commit_valid;
    arch_reg_t           commit_arch;
    preg_t               commit_preg;
    logic                flush;
    logic                rename_valid;
    logic                stall;
    preg_t               src1_preg;
    preg_t               src2_preg;
    preg_t               dest_preg;
    preg_t               old_dest_preg;
    logic [PREG_IDX_W:0] free_count;

    // ==============================
    // reference model
    // ==============================

    // allocatable registers, head first
    int free_q [$];
    // allocations not yet committed, oldest first
    int rob_arch [$];
    int rob_preg [$];
    int spec_map [NUM_ARCH_REGS];
    int arch_model [NUM_ARCH_REGS];

    int error_count;
    int cycle_count;
    int seed;

    rename_stage #(.PHYS_REGS(PHYS_REGS)) rename_stage_i (
        .clock               (clock),
        .reset               (reset),
        .dispatch_valid_i    (dispatch_valid),
        .dispatch_has_dest_i (dispatch_has_dest),
        .dispatch_dest_i     (dispatch_dest),
        .dispatch_src1_i     (dispatch_src1),
        .dispatch_src2_i     (dispatch_src2),
        .commit_valid_i      (commit_valid),
        .commit_arch_i       (commit_arch),
        .commit_preg_i       (commit_preg),
        .flush_i             (flush),
        .rename_valid_o      (rename_valid),
        .stall_o             (stall),
        .src1_preg_o         (src1_preg),
        .src2_preg_o         (src2_preg),
        .dest_preg_o         (dest_preg),
        .old_dest_preg_o     (old_dest_preg),
        .free_count_o        (free_count)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAIL");
            $fatal(1, "timeout");
        end
    end

    // ==============================
    // helpers
    // ==============================

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            error_count++;
            $display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
            $display("TEST FAIL");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    task automatic drive_idle();
        dispatch_valid    = 1'b0;
        dispatch_has_dest = 1'b0;
        dispatch_dest     = '0;
        dispatch_src1     = '0;
        dispatch_src2     = '0;
        commit_valid      = 1'b0;
        commit_arch       = '0;
        commit_preg       = '0;
        flush             = 1'b0;
    endtask

    // ring after reset holds 32..PHYS_REGS-1
    task automatic reset_model();
        free_q.delete();
        rob_arch.delete();
        rob_preg.delete();
        for (int i = 0; i < CAPACITY; i++) begin
            free_q.push_back(NUM_ARCH_REGS + i);
        end
        for (int i = 0; i < NUM_ARCH_REGS; i++) begin
            spec_map[i] = i;
            arch_model[i] = i;
        end
    endtask

    // one dispatch cycle entered and left 1 ns after an edge
    task automatic dispatch_one(input string name, input logic has_dest, input int dest,
                                input int src1, input int src2);
        logic need;
        int   exp_dest;
        int   exp_old;
        need = has_dest && (dest != 0);
        dispatch_valid    = 1'b1;
        dispatch_has_dest = has_dest;
        dispatch_dest     = arch_reg_t'(dest);
        dispatch_src1     = arch_reg_t'(src1);
        dispatch_src2     = arch_reg_t'(src2);
        #1;
        compare_value({name, " stall"}, 32'(free_q.size() == 0), 32'(stall));
        compare_value({name, " free count"}, 32'(free_q.size()), 32'(free_count));
        // reads see the map before this rename
        compare_value({name, " src1"}, 32'(spec_map[src1]), 32'(src1_preg));
        compare_value({name, " src2"}, 32'(spec_map[src2]), 32'(src2_preg));
        if (need && free_q.size() == 0) begin
            // dropped so nothing changes
            compare_value({name, " valid"}, 32'd0, 32'(rename_valid));
        end else begin
            compare_value({name, " valid"}, 32'd1, 32'(rename_valid));
            exp_dest = 0;
            exp_old = 0;
            if (need) begin
                exp_old = spec_map[dest];
                exp_dest = free_q.pop_front();
                spec_map[dest] = exp_dest;
                rob_arch.push_back(dest);
                rob_preg.push_back(exp_dest);
            end
            compare_value({name, " dest"}, 32'(exp_dest), 32'(dest_preg));
            compare_value({name, " old dest"}, 32'(exp_old), 32'(old_dest_preg));
        end
        @(posedge clock);
        #1;
        drive_idle();
    endtask

    // retire the oldest allocating instruction
    task automatic commit_oldest(input string name);
        int arch;
        int preg;
        if (rob_preg.size() == 0) begin
            $display("%s: no instruction left to commit", name);
            $display("TEST FAIL");
            $fatal(1, "empty reorder buffer");
        end
        arch = rob_arch.pop_front();
        preg = rob_preg.pop_front();
        commit_valid = 1'b1;
        commit_arch  = arch_reg_t'(arch);
        commit_preg  = preg_t'(preg);
        #1;
        compare_value({name, " count before"}, 32'(free_q.size()), 32'(free_count));
        free_q.push_back(arch_model[arch]);
        arch_model[arch] = preg;
        @(posedge clock);
        #1;
        drive_idle();
        // released register counted one cycle later
        compare_value({name, " count after"}, 32'(free_q.size()), 32'(free_count));
    endtask

    // squashed registers go back in front of the free ones
    task automatic flush_all(input string name);
        flush = 1'b1;
        @(posedge clock);
        #1;
        drive_idle();
        for (int i = rob_preg.size() - 1; i >= 0; i--) begin
            free_q.push_front(rob_preg[i]);
        end
        rob_arch.delete();
        rob_preg.delete();
        for (int i = 0; i < NUM_ARCH_REGS; i++) begin
            spec_map[i] = arch_model[i];
        end
        compare_value({name, " count"}, 32'(free_q.size()), 32'(free_count));
    endtask

    // two map entries per cycle without dispatch
    task automatic verify_map(input string name);
        for (int i = 0; i < NUM_ARCH_REGS; i += 2) begin
            dispatch_src1 = arch_reg_t'(i);
            dispatch_src2 = arch_reg_t'(i + 1);
            #1;
            compare_value({name, " map even"}, 32'(spec_map[i]), 32'(src1_preg));
            compare_value({name, " map odd"}, 32'(spec_map[i + 1]), 32'(src2_preg));
            @(posedge clock);
            #1;
        end
        drive_idle();
    endtask

    // ==============================
    // tests
    // ==============================

    task automatic reset_state_test();
        compare_value("reset_state valid", 32'd0, 32'(rename_valid));
        compare_value("reset_state stall", 32'd0, 32'(stall));
        compare_value("reset_state count", 32'(CAPACITY), 32'(free_count));
        verify_map("reset_state");
        dispatch_one("reset_state alloc x1", 1'b1, 1, 1, 2);
        dispatch_one("reset_state alloc x2", 1'b1, 2, 3, 4);
        dispatch_one("reset_state alloc x3", 1'b1, 3, 2, 3);
    endtask

    task automatic dependency_test();
        dispatch_one("dependency x5", 1'b1, 5, 1, 0);
        // reads the register given to x5 just before
        dispatch_one("dependency x6 reads x5", 1'b1, 6, 5, 5);
        dispatch_one("dependency dest x0", 1'b1, 0, 6, 3);
        dispatch_one("dependency no dest", 1'b0, 7, 6, 7);
        // own source sees the old x7
        dispatch_one("dependency x7 reads x7", 1'b1, 7, 6, 7);
    endtask

    task automatic exhaustion_test();
        int dest;
        int src1;
        int src2;
        while (free_q.size() > 0) begin
            dest = 1 + int'($unsigned($random(seed)) % 31);
            src1 = int'($unsigned($random(seed)) % 32);
            src2 = int'($unsigned($random(seed)) % 32);
            dispatch_one("exhaustion fill", 1'b1, dest, src1, src2);
        end
        dispatch_one("exhaustion dropped", 1'b1, 9, 9, 10);
        // x9 must still hold its mapping from before the drop
        dispatch_one("exhaustion no dest", 1'b0, 9, 9, 12);
    endtask

    task automatic commit_release_test();
        for (int i = 0; i < 4; i++) begin
            commit_oldest("commit_release commit");
        end
        // freed registers come back in release order
        dispatch_one("commit_release alloc a", 1'b1, 12, 1, 2);
        dispatch_one("commit_release alloc b", 1'b1, 13, 12, 3);
        dispatch_one("commit_release alloc c", 1'b1, 14, 13, 5);
    endtask

    task automatic flush_recovery_test();
        commit_oldest("flush_recovery commit a");
        commit_oldest("flush_recovery commit b");
        flush_all("flush_recovery");
        verify_map("flush_recovery");
        // squashed registers handed out again oldest first
        dispatch_one("flush_recovery alloc a", 1'b1, 4, 6, 7);
        dispatch_one("flush_recovery alloc b", 1'b1, 8, 4, 1);
        dispatch_one("flush_recovery alloc c", 1'b1, 4, 4, 8);
        dispatch_one("flush_recovery alloc d", 1'b1, 20, 21, 22);
    endtask

    // ==============================
    // sequence
    // ==============================

    initial begin
        drive_idle();
        reset = 1'b1;
        error_count = 0;
        cycle_count = 0;
        seed = 32'h8c18_20e6;
        reset_model();
        repeat (5) @(posedge clock);
        #1;
        reset = 1'b0;

        reset_state_test();
        dependency_test();
        exhaustion_test();
        commit_release_test();
        flush_recovery_test();

        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: sources.f
rtl/isa_pkg.sv
rtl/uarch_pkg.sv
rtl/free_list.sv
rtl/map_table.sv
rtl/arch_map.sv
rtl/rename_stage.sv
sim/tb_rename_stage.sv

// File: Makefile
# Verilator build and run for the rename stage

VERILATOR ?= verilator
TOP       ?= tb_rename_stage
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --assert --timescale $(TIMESCALE)

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# pass only when the pass line shows up in the output
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'TEST PASS'

clean:
	rm -rf $(BUILD_DIR)
